//--- dv/control_unit_properties.sv
`timescale 1ns/1ps

module control_unit_properties
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input logic         clk,
    input logic         rst,
    input ctrl_bundle_t ctrl
);

    int assert_failures = 0;  // Bumped by every failing assertion

    // Carry flag cannot be set and cleared together
    property p_setc_clrc_exclusive;
        @(posedge clk) disable iff (rst) !(ctrl.flag.setc && ctrl.flag.clrc);
    endproperty

    // A flushed fetch always comes with a PC update
    property p_flush_needs_pc_write;
        @(posedge clk) disable iff (rst) ctrl.pc.flush |-> ctrl.pc.pc_write;
    endproperty

    // Stores never target the fetch address
    property p_write_addr_not_pc;
        @(posedge clk) disable iff (rst) ctrl.mem.mem_write |-> (ctrl.mem.addr_sel != ADDR_PC);
    endproperty

    property p_push_pop_exclusive;
        @(posedge clk) disable iff (rst) !(ctrl.mem.stack_push && ctrl.mem.stack_pop);
    endproperty

    a_setc_clrc: assert property (p_setc_clrc_exclusive) else begin
        assert_failures++;
        $error("setc and clrc both high");
    end
    a_flush_pc: assert property (p_flush_needs_pc_write) else begin
        assert_failures++;
        $error("flush without pc_write");
    end
    a_wr_addr: assert property (p_write_addr_not_pc) else begin
        assert_failures++;
        $error("mem_write with ADDR_PC");
    end
    a_push_pop: assert property (p_push_pop_exclusive) else begin
        assert_failures++;
        $error("stack push and pop together");
    end

endmodule

//--- dv/control_unit_tb.sv
`timescale 1ns/1ps
`include "cu_cfg.svh"

module control_unit_tb
    import isa_pkg::*;
    import ctrl_pkg::*;
();

    localparam int NUM_CYCLES  = 3000;
    localparam int CLK_PERIOD  = 10;
    localparam int WATCHDOG_NS = 2 * NUM_CYCLES * CLK_PERIOD;  // Twice the expected run

    logic         clk;
    logic         rst;
    instr_t       instr;
    flags_t       flags;
    logic         interrupt;
    ctrl_bundle_t ctrl;

    ctrl_bundle_t exp_ctrl;     // Model output for the current cycle
    cu_state_e    model_state;  // Model copy of the sequencer state
    cu_state_e    prev_state;
    logic [31:0]  rng_state;
    int           cycle;
    int           cnt_fetch2, cnt_loop_taken, cnt_loop_exit, cnt_int, cnt_int_nested;
    int           cnt_br_taken, cnt_br_not, cnt_call, cnt_rti;

    control_unit UUT (
        .clk       (clk),
        .rst       (rst),
        .instr     (instr),
        .flags     (flags),
        .interrupt (interrupt),
        .ctrl      (ctrl)
    );

    bind control_unit control_unit_properties u_props (
        .clk  (clk),
        .rst  (rst),
        .ctrl (ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not complete within %0d ns", WATCHDOG_NS);
        abort_run();
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;  // Numerical Recipes constants
    endfunction

    // Expected bundle from the ISA rules, organized by opcode
    function automatic ctrl_bundle_t expected_bundle(input cu_state_e st, input instr_t ins,
                                                     input flags_t fl);
        ctrl_bundle_t e;
        logic         taken;
        e = '0;
        if (st == FETCH2) begin
            e.mem.mem_read = 1'b1;
            e.pc.ir_write  = 1'b1;
            e.pc.pc_write  = 1'b1;
        end else if (st == INT_HANDLE) begin
            e.flag.save_flags     = 1'b1;
            e.flag.interrupt_save = 1'b1;
            e.mem.stack_push      = 1'b1;  // push_pc_next stays 0
            e.mem.mem_write       = 1'b1;
            e.mem.mem_read        = 1'b1;
            e.mem.addr_sel        = ADDR_SP;
            e.pc.pc_write         = 1'b1;
            e.pc.pc_src           = PC_VEC1;
            e.pc.flush            = 1'b1;
        end else if (st == LOOP_DECIDE) begin
            e.pc.pc_write  = 1'b1;
            e.pc.ir_write  = 1'b1;
            e.mem.mem_read = 1'b1;
            e.pc.pc_src    = fl.z ? PC_INC : PC_REG;  // Loop back while z clear
            e.pc.flush     = !fl.z;
        end else begin
            e.mem.mem_read = 1'b1;
            e.pc.pc_write  = 1'b1;
            e.pc.ir_write  = 1'b1;
            case (ins.opcode)
                OP_MOV, OP_ADD, OP_SUB, OP_AND, OP_OR: begin
                    case (ins.opcode)
                        OP_MOV:  e.alu.alu_op = ALU_PASS_B;
                        OP_ADD:  e.alu.alu_op = ALU_ADD;
                        OP_SUB:  e.alu.alu_op = ALU_SUB;
                        OP_AND:  e.alu.alu_op = ALU_AND;
                        default: e.alu.alu_op = ALU_OR;
                    endcase
                    e.rf = '{reg_write: 1'b1, reg_dest: ins.ra, wb_sel: WB_ALU};
                end
                OP_ROT_CARRY: begin
                    if (ins.ra == ROT_SETC) begin
                        e.flag.setc = 1'b1;
                    end else if (ins.ra == ROT_CLRC) begin
                        e.flag.clrc = 1'b1;
                    end else begin
                        e.alu.alu_op = ALU_ROT;  // RLC or RRC
                        e.rf = '{reg_write: 1'b1, reg_dest: ins.rb, wb_sel: WB_ALU};
                    end
                end
                OP_UNARY: begin
                    e.alu.alu_op = ALU_UNARY;
                    e.rf = '{reg_write: 1'b1, reg_dest: ins.rb, wb_sel: WB_ALU};
                end
                OP_COND_BRANCH: begin
                    case (ins.ra)
                        BRX_Z:   taken = fl.z;
                        BRX_N:   taken = fl.n;
                        BRX_C:   taken = fl.c;
                        default: taken = fl.v;
                    endcase
                    e.pc.pc_src = taken ? PC_REG : PC_INC;
                    e.pc.flush  = taken;
                end
                OP_LOOP: begin
                    e.alu.alu_op = ALU_UNARY;
                    e.alu.dec_ra = 1'b1;
                    e.rf = '{reg_write: 1'b1, reg_dest: ins.ra, wb_sel: WB_ALU};
                end
                OP_JUMP: begin
                    if (ins.ra == JSUB_JMP) begin
                        e.pc.pc_src = PC_REG;
                        e.pc.flush  = 1'b1;
                    end else if (ins.ra == JSUB_CALL) begin
                        e.pc.pc_src         = PC_REG;  // No flush on CALL
                        e.mem.stack_push    = 1'b1;
                        e.mem.mem_write     = 1'b1;
                        e.mem.addr_sel      = ADDR_SP;
                        e.mem.push_pc_next  = 1'b1;
                    end else begin
                        e.pc.pc_src          = PC_STACK;  // RET or RTI
                        e.mem.stack_pop      = 1'b1;
                        e.mem.pop_to_pc      = 1'b1;
                        e.pc.flush           = 1'b1;
                        e.flag.restore_flags = (ins.ra == JSUB_RTI);
                    end
                end
                OP_LOAD_STORE: begin
                    if (ins.ra != LDST_RSVD) begin
                        e.pc.ir_write  = 1'b0;  // Keep IR while the immediate arrives
                        e.pc.imm_write = 1'b1;
                        if (ins.ra == LDST_LDM) begin
                            e.rf = '{reg_write: 1'b1, reg_dest: ins.rb, wb_sel: WB_IMM};
                        end else if (ins.ra == LDST_LDD) begin
                            e.rf = '{reg_write: 1'b1, reg_dest: ins.rb, wb_sel: WB_MEM};
                            e.mem.addr_sel = ADDR_IMM;
                        end else begin
                            e.mem.mem_write = 1'b1;  // STD
                            e.mem.addr_sel  = ADDR_IMM;
                        end
                    end
                end
                default: ;  // NOP and dropped opcodes
            endcase
        end
        return e;
    endfunction

    function automatic cu_state_e next_model_state(input cu_state_e st, input instr_t ins,
                                                   input logic irq);
        if (st == INT_HANDLE) return IDLE;  // Entry lasts one cycle
        if (irq) return INT_HANDLE;
        if (st == IDLE && ins.opcode == OP_LOAD_STORE && ins.ra != LDST_RSVD) return FETCH2;
        if (st == IDLE && ins.opcode == OP_LOOP) return LOOP_DECIDE;
        return IDLE;
    endfunction

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "Run stopped after a failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h (cycle %0d, instr 0x%0h, state %0d)",
                     name, actual, expected, cycle, instr, model_state);
            abort_run();
        end
    endtask

    // Compare, count scenarios, then step the model
    task automatic check_cycle();
        exp_ctrl = expected_bundle(model_state, instr, flags);
        check_value("ctrl.alu", ctrl.alu, exp_ctrl.alu);
        check_value("ctrl.rf", ctrl.rf, exp_ctrl.rf);
        check_value("ctrl.mem", ctrl.mem, exp_ctrl.mem);
        check_value("ctrl.pc", ctrl.pc, exp_ctrl.pc);
        check_value("ctrl.flag", ctrl.flag, exp_ctrl.flag);
        check_value("assertion failures", UUT.u_props.assert_failures, 32'd0);
        if (model_state == FETCH2) cnt_fetch2++;
        if (model_state == LOOP_DECIDE && !flags.z) cnt_loop_taken++;
        if (model_state == LOOP_DECIDE && flags.z) cnt_loop_exit++;
        if (model_state == INT_HANDLE) cnt_int++;
        if (model_state == INT_HANDLE && prev_state != IDLE) cnt_int_nested++;
        if (model_state == IDLE && instr.opcode == OP_COND_BRANCH) begin
            if (exp_ctrl.pc.flush) cnt_br_taken++;
            else cnt_br_not++;
        end
        if (model_state == IDLE && exp_ctrl.mem.push_pc_next) cnt_call++;
        if (exp_ctrl.flag.restore_flags) cnt_rti++;
        prev_state  = model_state;
        model_state = next_model_state(model_state, instr, interrupt);
    endtask

    initial begin
        rst         = 1'b1;
        instr       = '0;
        flags       = '0;
        interrupt   = 1'b0;
        rng_state   = 32'h94580cb9;
        model_state = IDLE;
        prev_state  = IDLE;
        cycle       = 0;
        {cnt_fetch2, cnt_loop_taken, cnt_loop_exit, cnt_int, cnt_int_nested} = '0;
        {cnt_br_taken, cnt_br_not, cnt_call, cnt_rti} = '0;

        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_cycle();  // NOP bundle straight after reset

        for (cycle = 1; cycle <= NUM_CYCLES; cycle++) begin
            @(posedge clk);
            rng_state = lcg_next(rng_state);
            instr     <= rng_state[31 -: `CU_INSTR_W];
            rng_state = lcg_next(rng_state);
            flags     <= rng_state[31:28];
            interrupt <= (rng_state[19:16] == 4'h0);  // About 1 in 16
            @(negedge clk);
            check_cycle();
        end

        if (cnt_fetch2 > 0 && cnt_loop_taken > 0 && cnt_loop_exit > 0 && cnt_int > 0 &&
            cnt_int_nested > 0 && cnt_br_taken > 0 && cnt_br_not > 0 && cnt_call > 0 &&
            cnt_rti > 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("Random stimulus missed a required scenario: fetch2 %0d, loop %0d/%0d,",
                     cnt_fetch2, cnt_loop_taken, cnt_loop_exit);
            $display("  interrupt %0d/%0d, branch %0d/%0d, call %0d, rti %0d", cnt_int,
                     cnt_int_nested, cnt_br_taken, cnt_br_not, cnt_call, cnt_rti);
            abort_run();
        end
    end

endmodule

//--- filelist.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/instr_decoder.sv
hdl/cu_sequencer.sv
hdl/ctrl_encoder.sv
hdl/control_unit.sv
dv/control_unit_properties.sv
dv/control_unit_tb.sv

//--- hdl/control_unit.sv
`timescale 1ns/1ps

module control_unit
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  instr_t       instr,
    input  flags_t       flags,
    input  logic         interrupt,
    output ctrl_bundle_t ctrl
);

    decoded_t  decoded;  // Shared by sequencer and encoder
    cu_state_e state;

    // Opcode classification
    instr_decoder u_decoder (
        .instr   (instr),
        .decoded (decoded)
    );

    // Two-byte, loop and interrupt sequencing
    cu_sequencer u_sequencer (
        .clk       (clk),
        .rst       (rst),
        .interrupt (interrupt),
        .decoded   (decoded),
        .state     (state)
    );

    // Control bundle and branch resolution
    ctrl_encoder u_encoder (
        .state   (state),
        .decoded (decoded),
        .flags   (flags),
        .ctrl    (ctrl)
    );

endmodule

//--- hdl/ctrl_encoder.sv
`timescale 1ns/1ps

module ctrl_encoder
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  cu_state_e    state,
    input  decoded_t     decoded,
    input  flags_t       flags,
    output ctrl_bundle_t ctrl
);

    logic br_taken;

    // Branch condition picked by brx
    always_comb begin
        case (decoded.sub)
            BRX_Z:   br_taken = flags.z;
            BRX_N:   br_taken = flags.n;
            BRX_C:   br_taken = flags.c;
            BRX_V:   br_taken = flags.v;
            default: br_taken = 1'b0;
        endcase
    end

    always_comb begin
        ctrl                  = '0;        // Everything inactive
        ctrl.alu.alu_op       = ALU_NONE;
        ctrl.rf.wb_sel        = WB_MEM;
        ctrl.mem.addr_sel     = ADDR_PC;
        ctrl.pc.pc_src        = PC_INC;

        case (state)
            FETCH2: begin
                ctrl.mem.mem_read = 1'b1;    // Second byte from PC
                ctrl.pc.ir_write  = 1'b1;
                ctrl.pc.pc_write  = 1'b1;
                ctrl.pc.pc_src    = PC_INC;  // Net PC+2 over both cycles
            end

            INT_HANDLE: begin
                ctrl.flag.save_flags     = 1'b1;
                ctrl.flag.interrupt_save = 1'b1;
                ctrl.mem.stack_push      = 1'b1;
                ctrl.mem.push_pc_next    = 1'b0;  // Refetch interrupted instr
                ctrl.mem.mem_write       = 1'b1;
                ctrl.mem.mem_read        = 1'b1;  // Vector read
                ctrl.mem.addr_sel        = ADDR_SP;
                ctrl.pc.pc_write         = 1'b1;
                ctrl.pc.pc_src           = PC_VEC1;
                ctrl.pc.flush            = 1'b1;
            end

            LOOP_DECIDE: begin
                ctrl.pc.pc_write  = 1'b1;
                ctrl.pc.ir_write  = 1'b1;
                ctrl.mem.mem_read = 1'b1;
                if (!flags.z) begin
                    ctrl.pc.pc_src = PC_REG;  // Counter not yet zero
                    ctrl.pc.flush  = 1'b1;
                end else begin
                    ctrl.pc.pc_src = PC_INC;  // Fall out of the loop
                end
            end

            default: begin
                // Normal issue, per-class table
                ctrl.mem.mem_read = 1'b1;
                ctrl.pc.pc_write  = 1'b1;
                ctrl.pc.pc_src    = PC_INC;
                ctrl.pc.ir_write  = (decoded.cls != CLS_LDST);  // Hold IR for imm
                ctrl.alu.alu_op   = alu_op_e'(decoded.alu_op);

                case (decoded.cls)
                    CLS_ALU: begin
                        ctrl.rf.reg_write = 1'b1;
                        ctrl.rf.reg_dest  = decoded.ra;
                        ctrl.rf.wb_sel    = WB_ALU;
                    end
                    CLS_ROTATE, CLS_UNARY: begin
                        ctrl.rf.reg_write = 1'b1;
                        ctrl.rf.reg_dest  = decoded.rb;  // Operates in place on rb
                        ctrl.rf.wb_sel    = WB_ALU;
                    end
                    CLS_FLAG_SET: ctrl.flag.setc = 1'b1;
                    CLS_FLAG_CLR: ctrl.flag.clrc = 1'b1;
                    CLS_BRANCH: begin
                        if (br_taken) begin
                            ctrl.pc.pc_src = PC_REG;
                            ctrl.pc.flush  = 1'b1;
                        end
                    end
                    CLS_LOOP: begin
                        ctrl.alu.dec_ra   = 1'b1;  // ra minus one
                        ctrl.rf.reg_write = 1'b1;
                        ctrl.rf.reg_dest  = decoded.ra;
                        ctrl.rf.wb_sel    = WB_ALU;
                    end
                    CLS_JUMP: begin
                        case (decoded.sub)
                            JSUB_JMP: begin
                                ctrl.pc.pc_src = PC_REG;
                                ctrl.pc.flush  = 1'b1;
                            end
                            JSUB_CALL: begin
                                ctrl.pc.pc_src        = PC_REG;  // No flush here
                                ctrl.mem.stack_push   = 1'b1;
                                ctrl.mem.mem_write    = 1'b1;
                                ctrl.mem.addr_sel     = ADDR_SP;
                                ctrl.mem.push_pc_next = 1'b1;    // Return to PC+1
                            end
                            JSUB_RET, JSUB_RTI: begin
                                ctrl.pc.pc_src          = PC_STACK;
                                ctrl.mem.stack_pop      = 1'b1;
                                ctrl.mem.pop_to_pc      = 1'b1;
                                ctrl.pc.flush           = 1'b1;
                                ctrl.flag.restore_flags = (decoded.sub == JSUB_RTI);
                            end
                            default: ctrl.pc.pc_src = PC_INC;
                        endcase
                    end
                    CLS_LDST: begin
                        ctrl.pc.imm_write = 1'b1;  // Latch the second byte
                        case (decoded.sub)
                            LDST_LDM: begin
                                ctrl.rf.reg_write = 1'b1;
                                ctrl.rf.reg_dest  = decoded.rb;
                                ctrl.rf.wb_sel    = WB_IMM;
                            end
                            LDST_LDD: begin
                                ctrl.rf.reg_write = 1'b1;
                                ctrl.rf.reg_dest  = decoded.rb;
                                ctrl.rf.wb_sel    = WB_MEM;
                                ctrl.mem.addr_sel = ADDR_IMM;  // Effective address
                            end
                            LDST_STD: begin
                                ctrl.mem.mem_write = 1'b1;
                                ctrl.mem.addr_sel  = ADDR_IMM;
                            end
                            default: ctrl.pc.imm_write = 1'b1;
                        endcase
                    end
                    default: ctrl.pc.pc_src = PC_INC;  // NOP just advances
                endcase
            end
        endcase
    end

endmodule

//--- hdl/ctrl_pkg.sv
`include "cu_cfg.svh"

package ctrl_pkg;

    import isa_pkg::*;

    typedef enum logic [1:0] {
        IDLE        = 2'd0,  // Normal issue
        FETCH2      = 2'd1,  // Second byte of LDM, LDD, STD
        INT_HANDLE  = 2'd2,  // Interrupt entry
        LOOP_DECIDE = 2'd3   // LOOP branch decision
    } cu_state_e;

    typedef enum logic [2:0] {
        PC_INC   = 3'd0,  // PC+1
        PC_INC2  = 3'd1,  // PC+2
        PC_REG   = 3'd2,  // PC from R[rb]
        PC_STACK = 3'd3,  // Popped return address
        PC_VEC0  = 3'd4,  // M[0]
        PC_VEC1  = 3'd5   // M[1] interrupt vector
    } pc_src_e;

    typedef enum logic [1:0] {
        ADDR_PC  = 2'd0,
        ADDR_REG = 2'd1,  // Register-indirect, no user left
        ADDR_SP  = 2'd2,
        ADDR_IMM = 2'd3
    } mem_addr_sel_e;

    typedef enum logic [2:0] {
        WB_MEM = 3'd0,
        WB_PC  = 3'd1,
        WB_IMM = 3'd2,
        WB_ALU = 3'd3
    } wb_sel_e;

    typedef enum logic [`CU_ALU_OP_W-1:0] {
        ALU_NONE   = 4'd0,
        ALU_PASS_B = 4'd1,  // MOV
        ALU_ADD    = 4'd2,
        ALU_SUB    = 4'd3,
        ALU_AND    = 4'd4,
        ALU_OR     = 4'd5,
        ALU_ROT    = 4'd6,  // RLC and RRC share it
        ALU_UNARY  = 4'd8   // Unary group and LOOP decrement
    } alu_op_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    dec_ra;  // Decrement ra instead of unary op
    } alu_ctrl_t;

    typedef struct packed {
        logic     reg_write;
        reg_idx_t reg_dest;
        wb_sel_e  wb_sel;
    } rf_ctrl_t;

    typedef struct packed {
        logic          mem_read;
        logic          mem_write;
        mem_addr_sel_e addr_sel;
        logic          stack_push;
        logic          stack_pop;
        logic          push_pc_next;  // 1 pushes PC+1, 0 pushes PC
        logic          pop_to_pc;
    } mem_ctrl_t;

    typedef struct packed {
        logic    pc_write;
        pc_src_e pc_src;
        logic    ir_write;
        logic    imm_write;
        logic    flush;  // Kill the fetched instruction
    } pc_ctrl_t;

    typedef struct packed {
        logic setc;
        logic clrc;
        logic save_flags;
        logic restore_flags;
        logic interrupt_save;
    } flag_ctrl_t;

    typedef struct packed {
        alu_ctrl_t  alu;
        rf_ctrl_t   rf;
        mem_ctrl_t  mem;
        pc_ctrl_t   pc;
        flag_ctrl_t flag;
    } ctrl_bundle_t;

endpackage

//--- hdl/cu_cfg.svh
`ifndef CU_CFG_SVH
`define CU_CFG_SVH

// Widths shared by the control unit packages

// One instruction byte per fetch
`define CU_INSTR_W 8

// Upper nibble selects the instruction group
`define CU_OPCODE_W 4

// Four general registers R0..R3
`define CU_REG_IDX_W 2

// ALU operation code carried to the execute stage
`define CU_ALU_OP_W 4

`endif

//--- hdl/cu_sequencer.sv
`timescale 1ns/1ps

module cu_sequencer
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      interrupt,
    input  decoded_t  decoded,
    output cu_state_e state
);

    cu_state_e state_next;

    // State register
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Interrupt wins over the two-byte and loop paths
    always_comb begin
        state_next = IDLE;  // Default return to issue
        case (state)
            IDLE: begin
                if (interrupt) begin
                    state_next = INT_HANDLE;
                end else if (decoded.two_byte) begin
                    state_next = FETCH2;       // Fetch the immediate byte
                end else if (decoded.is_loop) begin
                    state_next = LOOP_DECIDE;  // Decide once ra is updated
                end else begin
                    state_next = IDLE;
                end
            end
            FETCH2: begin
                if (interrupt) begin
                    state_next = INT_HANDLE;
                end else begin
                    state_next = IDLE;
                end
            end
            LOOP_DECIDE: begin
                if (interrupt) begin
                    state_next = INT_HANDLE;
                end else begin
                    state_next = IDLE;
                end
            end
            INT_HANDLE: begin
                state_next = IDLE;  // Single entry cycle
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

endmodule

//--- hdl/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  instr_t   instr,
    output decoded_t decoded
);

    // Classify the byte and pick the ALU operation per group
    always_comb begin
        decoded          = '0;
        decoded.cls      = CLS_NOP;     // Unknown opcodes behave as NOP
        decoded.sub      = instr.ra;    // Sub-op always lives in ra
        decoded.ra       = instr.ra;
        decoded.rb       = instr.rb;
        decoded.alu_op   = ALU_NONE;
        decoded.two_byte = 1'b0;
        decoded.is_loop  = 1'b0;

        case (instr.opcode)
            OP_MOV: begin
                decoded.cls    = CLS_ALU;
                decoded.alu_op = ALU_PASS_B;  // R[ra] gets R[rb]
            end
            OP_ADD: begin
                decoded.cls    = CLS_ALU;
                decoded.alu_op = ALU_ADD;
            end
            OP_SUB: begin
                decoded.cls    = CLS_ALU;
                decoded.alu_op = ALU_SUB;
            end
            OP_AND: begin
                decoded.cls    = CLS_ALU;
                decoded.alu_op = ALU_AND;
            end
            OP_OR: begin
                decoded.cls    = CLS_ALU;
                decoded.alu_op = ALU_OR;
            end
            OP_ROT_CARRY: begin
                case (instr.ra)
                    ROT_RLC, ROT_RRC: begin
                        decoded.cls    = CLS_ROTATE;
                        decoded.alu_op = ALU_ROT;  // Direction comes from ra
                    end
                    ROT_SETC: decoded.cls = CLS_FLAG_SET;
                    ROT_CLRC: decoded.cls = CLS_FLAG_CLR;
                    default:  decoded.cls = CLS_NOP;
                endcase
            end
            OP_UNARY: begin
                decoded.cls    = CLS_UNARY;
                decoded.alu_op = ALU_UNARY;  // NOT, NEG, INC, DEC by ra
            end
            OP_COND_BRANCH: begin
                decoded.cls = CLS_BRANCH;  // Condition resolved downstream
            end
            OP_LOOP: begin
                decoded.cls     = CLS_LOOP;
                decoded.alu_op  = ALU_UNARY;  // Used with dec_ra
                decoded.is_loop = 1'b1;       // Extra decide cycle
            end
            OP_JUMP: begin
                decoded.cls = CLS_JUMP;
            end
            OP_LOAD_STORE: begin
                // Slot 3 had no load/store meaning and stays a NOP
                if (instr.ra != LDST_RSVD) begin
                    decoded.cls      = CLS_LDST;
                    decoded.two_byte = 1'b1;  // Immediate follows
                end
            end
            default: begin
                decoded.cls = CLS_NOP;  // 7, 13, 14, 15 land here
            end
        endcase
    end

endmodule

//--- hdl/isa_pkg.sv
`include "cu_cfg.svh"

package isa_pkg;

    typedef logic [`CU_REG_IDX_W-1:0] reg_idx_t;

    typedef enum logic [`CU_OPCODE_W-1:0] {
        OP_NOP         = 4'd0,
        OP_MOV         = 4'd1,
        OP_ADD         = 4'd2,
        OP_SUB         = 4'd3,
        OP_AND         = 4'd4,
        OP_OR          = 4'd5,
        OP_ROT_CARRY   = 4'd6,   // RLC, RRC, SETC, CLRC
        OP_UNARY       = 4'd8,   // NOT, NEG, INC, DEC
        OP_COND_BRANCH = 4'd9,   // JZ, JN, JC, JV
        OP_LOOP        = 4'd10,
        OP_JUMP        = 4'd11,  // JMP, CALL, RET, RTI
        OP_LOAD_STORE  = 4'd12   // LDM, LDD, STD
    } opcode_e;

    // Sub-operation codes taken from the ra field
    localparam logic [1:0] ROT_RLC   = 2'd0;
    localparam logic [1:0] ROT_RRC   = 2'd1;
    localparam logic [1:0] ROT_SETC  = 2'd2;
    localparam logic [1:0] ROT_CLRC  = 2'd3;
    localparam logic [1:0] BRX_Z     = 2'd0;
    localparam logic [1:0] BRX_N     = 2'd1;
    localparam logic [1:0] BRX_C     = 2'd2;
    localparam logic [1:0] BRX_V     = 2'd3;
    localparam logic [1:0] JSUB_JMP  = 2'd0;
    localparam logic [1:0] JSUB_CALL = 2'd1;
    localparam logic [1:0] JSUB_RET  = 2'd2;
    localparam logic [1:0] JSUB_RTI  = 2'd3;
    localparam logic [1:0] LDST_LDM  = 2'd0;
    localparam logic [1:0] LDST_LDD  = 2'd1;
    localparam logic [1:0] LDST_STD  = 2'd2;
    localparam logic [1:0] LDST_RSVD = 2'd3;  // Former LDI slot

    typedef struct packed {
        logic [`CU_OPCODE_W-1:0]                             opcode;
        reg_idx_t                                            ra;  // Also brx
        logic [`CU_INSTR_W-`CU_OPCODE_W-`CU_REG_IDX_W-1:0]  rb;  // Remaining low bits
    } instr_t;

    typedef struct packed {
        logic z;
        logic n;
        logic c;
        logic v;
    } flags_t;

    typedef enum logic [3:0] {
        CLS_NOP, CLS_ALU, CLS_ROTATE, CLS_FLAG_SET, CLS_FLAG_CLR,
        CLS_UNARY, CLS_BRANCH, CLS_LOOP, CLS_JUMP, CLS_LDST
    } instr_class_e;

    typedef struct packed {
        instr_class_e             cls;
        logic [1:0]               sub;       // ra field reused as sub-op
        reg_idx_t                 ra;
        reg_idx_t                 rb;
        logic [`CU_ALU_OP_W-1:0]  alu_op;
        logic                     two_byte;  // LDM, LDD, STD
        logic                     is_loop;
    } decoded_t;

endpackage
